// File: hw/trace_params.svh
// instruction trace block, shared widths and depths
// used by the package and every RTL module

`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// sequence id given to each accepted fetch
`define TRACE_ID_W     8
// cycle stamp width, stamps wrap around
`define TRACE_STAMP_W  16

// trace buffer depth and occupancy count width
`define TRACE_DEPTH    8
`define TRACE_CNT_W    4

// AXI4-Lite slave
`define AXIL_ADDR_W    8
`define AXIL_DATA_W    32

`endif

// File: hw/trace_pkg.sv
// instruction trace block, shared types
// opcode classes, bus FSM states, pipeline slot and retired record
`default_nettype none

`include "trace_params.svh"

package trace_pkg;

    // opcode class reported by the CPU with each fetch
    typedef enum logic [3:0] {
        op_nop    = 4'd0,
        op_alu    = 4'd1,
        op_load   = 4'd2,
        op_store  = 4'd3,
        op_branch = 4'd4,
        op_jump   = 4'd5
    } op_t;

    // AXI4-Lite slave states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_rresp = 2'd1,
        st_bresp = 2'd2
    } axil_state_t;

    // capture control from the register block
    typedef struct packed {
        logic enable;
        logic clear;
    } ctrl_t;

    // retired record, 8 + 4 + 5 * 16 = 92 bits
    // stamp[0] fetch, [1] decode, [2] execute, [3] memory, [4] write-back
    typedef struct packed {
        logic [`TRACE_ID_W-1:0]         id;
        op_t                            op;
        logic [4:0][`TRACE_STAMP_W-1:0] stamp;
    } trace_rec_t;

    // one pipeline slot
    typedef struct packed {
        logic       valid;
        trace_rec_t rec;
    } stage_t;

endpackage

`default_nettype wire

// File: hw/cycle_timer.sv
// cycle timer for the trace block
// counts enabled clock edges to give each stage entry a stamp
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module cycle_timer (
    input  logic                      clk,
    input  logic                      rst,
    input  trace_pkg::ctrl_t          ctrl,
    output logic [`TRACE_STAMP_W-1:0] stamp
);

    // free running while enabled, wraps silently
    // stamps are only ever compared modulo their width
    always_ff @(posedge clk) begin
        if (rst) begin
            stamp <= '0;
        end else if (ctrl.clear) begin
            stamp <= '0;
        end else if (ctrl.enable) begin
            stamp <= stamp + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/stage_tracker.sv
// stage tracker, follows each fetched instruction through the five stages
// stamps every stage entry and emits a record when it leaves write-back
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module stage_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  trace_pkg::ctrl_t          ctrl,
    input  logic [`TRACE_STAMP_W-1:0] stamp,
    input  logic                      fetch_valid,
    input  logic                      stall,
    input  logic                      flush,
    input  trace_pkg::op_t            fetch_op,
    output logic                      retire_valid,
    output trace_pkg::trace_rec_t     retire_rec
);
    import trace_pkg::*;

    // slot 0 fetch, 1 decode, 2 execute, 3 memory, 4 write-back
    stage_t slot [0:4];
    stage_t nxt  [0:4];

    logic [`TRACE_ID_W-1:0] next_id;
    logic                   accept;

    // a stalled or flushed cycle takes no new fetch
    assign accept = fetch_valid & ~stall & ~flush;

    //////////////////////////////////////////////////
    // next slot contents
    //////////////////////////////////////////////////

    always_comb begin
        // plain advance, each slot stamps the stage it enters
        for (int s = 1; s < 5; s++) begin
            nxt[s]              = slot[s-1];
            nxt[s].rec.stamp[s] = stamp;
        end

        // new fetch takes the next id and the current stamp
        nxt[0].valid        = accept;
        nxt[0].rec.id       = next_id;
        nxt[0].rec.op       = fetch_op;
        nxt[0].rec.stamp    = '0;
        nxt[0].rec.stamp[0] = stamp;

        // stall holds fetch and decode
        // execute gets a bubble, memory and write-back still drain
        if (stall) begin
            nxt[0]       = slot[0];
            nxt[1]       = slot[1];
            nxt[2].valid = 1'b0;
        end

        // flush leaves fetch and decode empty after this edge
        // the old decode slot still moves on unless stalled
        if (flush) begin
            nxt[0].valid = 1'b0;
            nxt[1].valid = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // slot registers and id counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 5; s++) begin
                slot[s].valid <= 1'b0;
            end
            next_id <= '0;
        end else if (ctrl.clear) begin
            // clear empties the pipeline view so ids restart at 0
            for (int s = 0; s < 5; s++) begin
                slot[s].valid <= 1'b0;
            end
            next_id <= '0;
        end else if (ctrl.enable) begin
            slot <= nxt;
            if (accept) begin
                next_id <= next_id + 1'b1;
            end
        end
    end

    // write-back slot leaves on the same edge it is pushed
    // nothing retires while capture is off, the slot just waits
    assign retire_valid = ctrl.enable & slot[4].valid;
    assign retire_rec   = slot[4].rec;

endmodule

`default_nettype wire

// File: hw/trace_buffer.sv
// trace buffer, circular FIFO of retired records
// no back-pressure, pushes into a full buffer are counted as drops
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module trace_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  trace_pkg::ctrl_t        ctrl,
    input  logic                    push,
    input  trace_pkg::trace_rec_t   push_rec,
    input  logic                    pop,
    output trace_pkg::trace_rec_t   head_rec,
    output logic [`TRACE_CNT_W-1:0] count,
    output logic [7:0]              dropped
);
    import trace_pkg::*;

    localparam int ptr_w = $clog2(`TRACE_DEPTH);

    trace_rec_t mem [0:`TRACE_DEPTH-1];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == `TRACE_CNT_W'(`TRACE_DEPTH));
    assign do_push = push & ~full;
    // empty pop is ignored
    assign do_pop  = pop & (count != '0);

    //////////////////////////////////////////////////
    // pointers, occupancy and drop counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || ctrl.clear) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // saturates at 255
            if (push && full && dropped != 8'hff) begin
                dropped <= dropped + 1'b1;
            end
        end
    end

    // record storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    assign head_rec = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/axil_trace_ctrl.sv
// AXI4-Lite register block for the trace unit
// control and status registers, record readout and pop on word 2
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module axil_trace_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    // write address and data channels
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    // write response
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    // read address and data channels
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,
    // trace buffer side
    input  trace_pkg::trace_rec_t   head_rec,
    input  logic [`TRACE_CNT_W-1:0] count,
    input  logic [7:0]              dropped,
    output logic                    pop,
    output trace_pkg::ctrl_t        ctrl
);
    import trace_pkg::*;

    localparam int data_w = `AXIL_DATA_W;

    localparam logic [`AXIL_ADDR_W-1:0] addr_ctrl   = 'h00;
    localparam logic [`AXIL_ADDR_W-1:0] addr_status = 'h04;
    localparam logic [`AXIL_ADDR_W-1:0] addr_rec0   = 'h08;
    localparam logic [`AXIL_ADDR_W-1:0] addr_rec1   = 'h0c;
    localparam logic [`AXIL_ADDR_W-1:0] addr_rec2   = 'h10;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    axil_state_t       state;
    logic [data_w-1:0] rd_data;
    logic [1:0]        rd_resp;
    logic              rd_pop;
    logic              rec_addr;
    logic              rec_avail;
    logic              pop_armed;
    logic              wr_hs;
    logic              rd_hs;

    // address and data are taken together in one beat
    assign wr_hs = (state == st_idle) & awready & awvalid & wvalid;
    assign rd_hs = (state == st_idle) & arready & arvalid;

    //////////////////////////////////////////////////
    // read decode
    //////////////////////////////////////////////////

    assign rec_addr  = (araddr == addr_rec0) | (araddr == addr_rec1) | (araddr == addr_rec2);
    assign rec_avail = (count != '0);

    always_comb begin
        rd_data = '0;
        rd_resp = resp_okay;
        rd_pop  = 1'b0;
        case (araddr)
            addr_ctrl:   rd_data = data_w'(ctrl.enable);
            addr_status: rd_data = data_w'({dropped, {(8-`TRACE_CNT_W){1'b0}}, count});
            addr_rec0:   rd_data = {4'b0000, head_rec.op, head_rec.id, head_rec.stamp[0]};
            addr_rec1:   rd_data = {head_rec.stamp[1], head_rec.stamp[2]};
            addr_rec2: begin
                rd_data = {head_rec.stamp[3], head_rec.stamp[4]};
                rd_pop  = 1'b1;
            end
            default:     rd_resp = resp_slverr;
        endcase
        // record words need something in the buffer
        if (rec_addr && !rec_avail) begin
            rd_data = '0;
            rd_resp = resp_slverr;
            rd_pop  = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // bus FSM and control bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            pop_armed <= 1'b0;
            ctrl      <= '0;
        end else begin
            // ready and clear are single cycle pulses
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            ctrl.clear <= 1'b0;
            case (state)
                st_idle: begin
                    if (wr_hs) begin
                        if (awaddr == addr_ctrl) begin
                            ctrl.enable <= wdata[0];
                            ctrl.clear  <= wdata[1];
                        end
                        bvalid <= 1'b1;
                        state  <= st_bresp;
                    end else if (rd_hs) begin
                        rvalid    <= 1'b1;
                        pop_armed <= rd_pop;
                        state     <= st_rresp;
                    end else if (awvalid && wvalid && !arready) begin
                        // write wins over a read arriving together
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end else if (arvalid && !awready) begin
                        arready <= 1'b1;
                    end
                end
                st_bresp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                st_rresp: begin
                    if (rready) begin
                        rvalid    <= 1'b0;
                        pop_armed <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // response payload, held until the matching handshake
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            // only control is writable
            bresp <= (awaddr == addr_ctrl) ? resp_okay : resp_slverr;
        end
        if (rd_hs) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // head advances on the R handshake of a good word 2 read
    assign pop = rvalid & rready & pop_armed;

endmodule

`default_nettype wire

// File: hw/pipe_trace_top.sv
// pipeline trace top level
// timer, stage tracker, trace buffer and AXI4-Lite register block
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module pipe_trace_top (
    input  logic                    clk,
    input  logic                    rst,
    // CPU stage activity
    input  logic                    fetch_valid,
    input  trace_pkg::op_t          fetch_op,
    input  logic                    stall,
    input  logic                    flush,
    // AXI4-Lite slave
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp
);
    import trace_pkg::*;

    ctrl_t                      ctrl;
    logic [`TRACE_STAMP_W-1:0]  stamp;
    logic                       retire_valid;
    trace_rec_t                 retire_rec;
    trace_rec_t                 head_rec;
    logic [`TRACE_CNT_W-1:0]    count;
    logic [7:0]                 dropped;
    logic                       pop;

    cycle_timer timer_i (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (ctrl),
        .stamp (stamp)
    );

    stage_tracker tracker_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .stamp        (stamp),
        .fetch_valid  (fetch_valid),
        .stall        (stall),
        .flush        (flush),
        .fetch_op     (fetch_op),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    // tracker pushes straight in, no ready path back
    trace_buffer buffer_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .push     (retire_valid),
        .push_rec (retire_rec),
        .pop      (pop),
        .head_rec (head_rec),
        .count    (count),
        .dropped  (dropped)
    );

    axil_trace_ctrl ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .head_rec (head_rec),
        .count    (count),
        .dropped  (dropped),
        .pop      (pop),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// File: tests/trace_checker.sv
// bus and buffer assertions for the trace block
// bound into the top level, checks handshakes, stability and occupancy
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module trace_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    awready,
    input logic                    wready,
    input logic                    arready,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready,
    input logic [`AXIL_DATA_W-1:0] rdata,
    input logic [`TRACE_CNT_W-1:0] count
);

    //////////////////////////////////////////////////
    // response channels
    //////////////////////////////////////////////////

    // a pending B response stays up until taken
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // R response holds, and its data must not move
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    // occupancy bounded by the buffer depth
    cnt_max: assert property (@(posedge clk) disable iff (rst)
        count <= `TRACE_CNT_W'(`TRACE_DEPTH))
        else $error("buffer count above depth");

    // second reset cycle on, registers are already cleared
    rst_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !(awready || wready || arready || bvalid || rvalid))
        else $error("handshake output high during reset");

endmodule

bind pipe_trace_top trace_checker checker_i (
    .clk     (clk),
    .rst     (rst),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .count   (count)
);

`default_nettype wire

// File: tests/tb_pipe_trace.sv
// testbench for the pipeline trace block
// LFSR driven pipeline events, reference model of stages and buffer, AXI4-Lite readout
`timescale 1ns/100ps
`default_nettype none

`include "trace_params.svh"

module tb_pipe_trace;
    import trace_pkg::*;

    localparam int timeout = 200;

    logic clk = 1'b0;
    logic rst;
    logic fetch_valid, stall, flush;
    op_t  fetch_op;
    logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
    logic [`AXIL_DATA_W-1:0] wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready;
    logic rvalid, rready;
    logic [1:0] bresp, rresp;

    // model state
    logic [15:0] lfsr;
    logic        m_valid [0:4];
    trace_rec_t  m_rec [0:4];
    logic [`TRACE_STAMP_W-1:0] m_stamp;
    logic [`TRACE_ID_W-1:0]    m_id;
    trace_rec_t  exp_q [$];
    int          m_drops;
    bit          m_en, m_clr;
    int          prev_id;

    pipe_trace_top dut_i (.*);

    always #20 clk = ~clk;

    initial begin
        #2_000_000;
        $display("sim failed");
        $fatal(1, "simulation ran past its time limit");
    end

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`AXIL_DATA_W-1:0] exp_status();
        return {16'h0, 8'(m_drops), 4'h0, 4'(exp_q.size())};
    endfunction

    //////////////////////////////////////////////////
    // reference model, one step per enabled edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst || m_clr) begin
            for (int s = 0; s < 5; s++) m_valid[s] = 1'b0;
            m_stamp = '0;
            m_id    = '0;
            m_drops = 0;
            exp_q.delete();
        end else if (m_en) begin
            // write-back leaves first, full buffer drops it
            if (m_valid[4]) begin
                if (exp_q.size() >= `TRACE_DEPTH) begin
                    if (m_drops < 255) m_drops++;
                end else begin
                    exp_q.push_back(m_rec[4]);
                end
            end
            for (int s = 4; s >= 1; s--) begin
                if (!stall || s >= 3) begin
                    m_valid[s]          = m_valid[s-1];
                    m_rec[s]            = m_rec[s-1];
                    m_rec[s].stamp[s]   = m_stamp;
                end
            end
            if (stall) begin
                // execute takes a bubble, fetch and decode hold
                m_valid[2] = 1'b0;
            end else begin
                m_valid[0]          = fetch_valid && !flush;
                m_rec[0].id         = m_id;
                m_rec[0].op         = fetch_op;
                m_rec[0].stamp      = '0;
                m_rec[0].stamp[0]   = m_stamp;
                if (fetch_valid && !flush) m_id++;
            end
            if (flush) begin
                m_valid[0] = 1'b0;
                m_valid[1] = 1'b0;
            end
            m_stamp++;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input logic [`AXIL_DATA_W-1:0] got,
                              input logic [`AXIL_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("sim failed");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite tasks, entered 2 ns after an edge
    //////////////////////////////////////////////////

    task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr,
                              input logic [`AXIL_DATA_W-1:0] data);
        int waited;
        int gap;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        // address and data ready rise together
        while (!(awready && wready)) begin
            waited++;
            if (waited > timeout) timeout_abort("awready and wready");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (addr == 8'h00) begin
            m_en  = data[0];
            m_clr = data[1];
        end
        // clear lasts exactly one edge
        @(posedge clk);
        #2;
        m_clr = 1'b0;
        gap   = int'(rand_bits(2));
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!bvalid) begin
            waited++;
            if (waited > timeout) timeout_abort("bvalid");
            @(negedge clk);
        end
        check_resp("bresp", bresp, 2'b00);
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr,
                             output logic [`AXIL_DATA_W-1:0] data, output logic [1:0] resp);
        int waited;
        int gap;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!arready) begin
            waited++;
            if (waited > timeout) timeout_abort("arready");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        gap     = int'(rand_bits(2));
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!rvalid) begin
            waited++;
            if (waited > timeout) timeout_abort("rvalid");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
        // word 2 read of a non-empty buffer retires the head
        if (addr == 8'h10 && exp_q.size() > 0) void'(exp_q.pop_front());
    endtask

    //////////////////////////////////////////////////
    // stimulus and readout helpers
    //////////////////////////////////////////////////

    task automatic drive_cycle(input bit active, input bit hazards);
        @(posedge clk);
        #2;
        fetch_valid = active && (rand_bits(2) != 0);
        fetch_op    = op_t'(4'(rand_bits(3) % 6));
        stall       = active && hazards && (rand_bits(3) == 0);
        flush       = active && hazards && (rand_bits(4) == 0);
    endtask

    task automatic read_rec(output trace_rec_t got);
        logic [`AXIL_DATA_W-1:0] w0, w1, w2;
        logic [1:0]              r;
        trace_rec_t              exp;
        if (exp_q.size() == 0) begin
            $display("sim failed");
            $fatal(1, "a record was expected but the model holds none");
        end else begin
            exp = exp_q[0];
            axil_read(8'h08, w0, r);
            check_resp("rresp word 0", r, 2'b00);
            axil_read(8'h0c, w1, r);
            check_resp("rresp word 1", r, 2'b00);
            axil_read(8'h10, w2, r);
            check_resp("rresp word 2", r, 2'b00);
            got.id       = w0[23:16];
            got.op       = op_t'(w0[27:24]);
            got.stamp[0] = w0[15:0];
            got.stamp[1] = w1[31:16];
            got.stamp[2] = w1[15:0];
            got.stamp[3] = w2[31:16];
            got.stamp[4] = w2[15:0];
            check_rec("retire_rec", got, exp);
        end
    endtask

    // disable capture, then read every record the model expects
    task automatic drain_all(input bit strict);
        trace_rec_t              got;
        logic [`AXIL_DATA_W-1:0] d;
        logic [1:0]              r;
        axil_write(8'h00, 32'h0);
        while (exp_q.size() > 0) begin
            read_rec(got);
            if (strict) begin
                if (prev_id >= 0) check_word("id", 32'(got.id), 32'((prev_id + 1) % 256));
                for (int s = 1; s < 5; s++) begin
                    check_word("stamp", 32'(got.stamp[s]), 32'(got.stamp[s-1] + 16'd1));
                end
            end
            prev_id = int'(got.id);
        end
        axil_read(8'h04, d, r);
        check_resp("rresp status", r, 2'b00);
        check_word("status", d, 32'h0);
    endtask

    task automatic run_phase(input int cycles, input bit hazards, input bit strict);
        axil_write(8'h00, 32'h1);
        for (int c = 0; c < cycles + 6; c++) begin
            drive_cycle(c < cycles, hazards);
            if (exp_q.size() >= 6) begin
                drain_all(strict);
                axil_write(8'h00, 32'h1);
            end
        end
        drain_all(strict);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [`AXIL_DATA_W-1:0] d;
        logic [1:0]              r;
        trace_rec_t              got;
        int                      n;
        lfsr = 16'd14;
        rst = 1'b1;
        {fetch_valid, stall, flush, awvalid, wvalid, bready, arvalid, rready} = '0;
        fetch_op = op_nop;
        awaddr = '0;
        araddr = '0;
        wdata  = '0;
        m_en   = 1'b0;
        m_clr  = 1'b0;
        prev_id = -1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset values and error responses
        axil_read(8'h04, d, r);
        check_resp("rresp status", r, 2'b00);
        check_word("status", d, 32'h0);
        axil_read(8'h00, d, r);
        check_resp("rresp control", r, 2'b00);
        check_word("control", d, 32'h0);
        axil_read(8'h08, d, r);
        check_resp("rresp empty record", r, 2'b10);
        check_word("rdata empty record", d, 32'h0);
        axil_read(8'h20, d, r);
        check_resp("rresp unmapped", r, 2'b10);
        check_word("rdata unmapped", d, 32'h0);

        // clean pipeline, then stalls and flushes
        run_phase(40, 1'b0, 1'b1);
        run_phase(120, 1'b1, 1'b0);

        // overflow with no reads
        axil_write(8'h00, 32'h1);
        n = 0;
        while (m_drops < 3) begin
            drive_cycle(1'b1, 1'b0);
            n++;
            if (n > 400) timeout_abort("buffer overflow");
        end
        fetch_valid = 1'b0;
        axil_write(8'h00, 32'h0);
        axil_read(8'h04, d, r);
        check_resp("rresp status", r, 2'b00);
        check_word("status", d, exp_status());
        check_word("status count", 32'(d[3:0]), 32'd8);
        repeat (8) read_rec(got);

        // clear, then fetches while disabled are ignored
        axil_write(8'h00, 32'h2);
        axil_read(8'h04, d, r);
        check_resp("rresp status", r, 2'b00);
        check_word("status", d, 32'h0);
        fetch_valid = 1'b1;
        repeat (10) begin
            @(posedge clk);
            #2;
        end
        axil_read(8'h04, d, r);
        check_resp("rresp status", r, 2'b00);
        check_word("status", d, 32'h0);
        axil_write(8'h00, 32'h1);
        fetch_valid = 1'b0;
        repeat (8) drive_cycle(1'b0, 1'b0);
        axil_write(8'h00, 32'h0);
        read_rec(got);
        check_word("id", 32'(got.id), 32'h0);
        check_word("stamp", 32'(got.stamp[0]), 32'h0);
        while (exp_q.size() > 0) read_rec(got);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/trace_pkg.sv
hw/cycle_timer.sv
hw/stage_tracker.sv
hw/trace_buffer.sv
hw/axil_trace_ctrl.sv
hw/pipe_trace_top.sv
tests/trace_checker.sv
tests/tb_pipe_trace.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pipe_trace
FILELIST  = sources.f
OBJDIR    = obj_dir

SRCS    = $(shell grep -v '^+' $(FILELIST))
HEADERS = hw/trace_params.svh
BIN     = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
